// ==== hw/gpu_reg_pkg.sv ====
// bus word type, operating mode enum and register word addresses
`default_nettype none

package gpu_reg_pkg;

    // one data or address word on either bus
    typedef logic [31:0] bus_word_t;

    // operating mode as written by software, full word wide
    typedef enum logic [31:0] {
        mode_none        = 32'd0,
        mode_cube        = 32'd1,  // not implemented, completes at once
        mode_clear_frame = 32'd2,
        mode_clear_depth = 32'd3
    } gpu_mode_e;

    // word addresses of the slave registers
    // 4..7 and 9 and up are unmapped and read zero
    typedef enum logic [31:0] {
        reg_frame_ptr = 32'd0,
        reg_start     = 32'd1,
        reg_done      = 32'd2,
        reg_zbuf_ptr  = 32'd3,
        reg_mode      = 32'd8
    } reg_addr_e;

endpackage

`default_nettype wire

// ==== hw/gpu_frame_pkg.sv ====
// frame geometry defaults, pixel size, clear patterns and clear target enum
`default_nettype none

package gpu_frame_pkg;

    parameter int DEFAULT_FRAME_WIDTH  = 320;
    parameter int DEFAULT_FRAME_HEIGHT = 240;

    // address step between two pixels
    parameter int unsigned PIXEL_BYTES = 4;

    parameter logic [31:0] SKY_COLOR = 32'h0087CEEB;  // 00 RR GG BB
    parameter logic [31:0] DEPTH_FAR = 32'h7FFFFFFF;  // largest positive depth

    // which buffer a clear run fills
    typedef enum logic {
        target_frame = 1'b0,
        target_depth = 1'b1
    } clear_target_e;

endpackage

`default_nettype wire

// ==== hw/gpu_ctrl_if.sv ====
// control interface between register file, sequencer and clear engine
`timescale 1ns/1ns
`default_nettype none

interface gpu_ctrl_if
    import gpu_reg_pkg::*;
();

    bus_word_t frame_ptr;  // frame buffer base
    bus_word_t zbuf_ptr;   // depth buffer base
    gpu_mode_e mode;
    logic      start;
    logic      set_done;   // one cycle, run complete

    // register file owns the software visible state
    modport regs (
        output frame_ptr,
        output zbuf_ptr,
        output mode,
        output start,
        input  set_done
    );

    modport seq (
        input  mode,
        input  start,
        output set_done
    );

    // clear engine only needs the base pointers
    modport clear (
        input  frame_ptr,
        input  zbuf_ptr
    );

endinterface

`default_nettype wire

// ==== hw/gpu_regs.sv ====
// slave register file: write decode, read mux and done flag
`timescale 1ns/1ns
`default_nettype none

module gpu_regs
    import gpu_reg_pkg::*;
(
    input  wire logic      CLK,
    input  wire logic      RESET,
    input  wire logic      slave_chipselect,
    input  wire logic      slave_read,
    input  wire logic      slave_write,
    input  wire bus_word_t slave_address,
    input  wire bus_word_t slave_writedata,
    output bus_word_t      slave_readdata,
    gpu_ctrl_if.regs       ctrl
);

    bus_word_t frame_ptr;
    bus_word_t zbuf_ptr;
    gpu_mode_e mode;
    logic      start;
    logic      done;
    logic      wr_en;
    logic      rd_en;

    assign wr_en = slave_chipselect && slave_write;
    assign rd_en = slave_chipselect && slave_read;

    // register write, takes effect on the next edge
    always_ff @(posedge CLK) begin
        if (RESET) begin
            frame_ptr <= '0;
            zbuf_ptr  <= '0;
            mode      <= mode_none;
            start     <= 1'b0;
            done      <= 1'b0;
        end else begin
            if (wr_en) begin
                case (slave_address)
                    reg_frame_ptr: frame_ptr <= slave_writedata;
                    reg_start:     start     <= slave_writedata[0];
                    reg_zbuf_ptr:  zbuf_ptr  <= slave_writedata;
                    reg_mode:      mode      <= gpu_mode_e'(slave_writedata);
                    default: ;
                endcase
            end
            // completion wins over software
            if (ctrl.set_done) begin
                done <= 1'b1;
            end else if (wr_en && slave_address == reg_done) begin
                done <= slave_writedata[0];
            end
        end
    end

    // read mux, same cycle
    always_comb begin
        slave_readdata = '0;
        if (rd_en) begin
            case (slave_address)
                reg_frame_ptr: slave_readdata = frame_ptr;
                reg_start:     slave_readdata = {31'd0, start};
                reg_done:      slave_readdata = {31'd0, done};
                reg_zbuf_ptr:  slave_readdata = zbuf_ptr;
                reg_mode:      slave_readdata = bus_word_t'(mode);
                default:       slave_readdata = '0;  // unmapped
            endcase
        end
    end

    assign ctrl.frame_ptr = frame_ptr;
    assign ctrl.zbuf_ptr  = zbuf_ptr;
    assign ctrl.mode      = mode;
    assign ctrl.start     = start;

    // software clearing done while the sequencer completes would lose the event
    a_no_done_race : assert property (
        @(posedge CLK) disable iff (RESET)
        !(ctrl.set_done && wr_en && slave_address == reg_done)
    );

endmodule

`default_nettype wire

// ==== hw/gpu_sequencer.sv ====
// run sequencer: idle, running and done, with mode dispatch
`timescale 1ns/1ns
`default_nettype none

module gpu_sequencer
    import gpu_reg_pkg::*;
    import gpu_frame_pkg::*;
(
    input  wire logic CLK,
    input  wire logic RESET,
    gpu_ctrl_if.seq   ctrl,
    output logic      clear_go,
    output clear_target_e clear_target,
    input  wire logic clear_finish
);

    typedef enum logic [1:0] {
        st_idle,
        st_running,
        st_done
    } run_state_e;

    run_state_e    state;
    logic          run_clear;   // current run is a buffer clear
    clear_target_e run_target;
    logic          mode_is_clear;

    assign mode_is_clear = (ctrl.mode == mode_clear_frame) ||
                           (ctrl.mode == mode_clear_depth);

    // run kind is captured when leaving idle so a mode write mid run is harmless
    always_ff @(posedge CLK) begin
        if (RESET) begin
            state      <= st_idle;
            run_clear  <= 1'b0;
            run_target <= target_frame;
        end else begin
            case (state)
                st_idle: begin
                    if (ctrl.start) begin
                        state      <= st_running;
                        run_clear  <= mode_is_clear;
                        run_target <= (ctrl.mode == mode_clear_depth) ? target_depth
                                                                      : target_frame;
                    end
                end
                st_running: begin
                    if (ctrl.set_done) begin
                        state <= st_done;
                    end
                end
                st_done: begin
                    if (!ctrl.start) begin  // wait for software to drop start
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign clear_go     = (state == st_running) && run_clear;
    assign clear_target = run_target;

    // unsupported modes finish in their first running cycle
    assign ctrl.set_done = (state == st_running) && (run_clear ? clear_finish : 1'b1);

    // the clear engine may only finish a clear run that is in progress
    a_finish_in_clear_run : assert property (
        @(posedge CLK) disable iff (RESET)
        clear_finish |-> state == st_running && run_clear
    );

endmodule

`default_nettype wire

// ==== hw/buffer_clear.sv ====
// clear engine: word counter and master write generator
`timescale 1ns/1ns
`default_nettype none

module buffer_clear
    import gpu_reg_pkg::*;
    import gpu_frame_pkg::*;
#(
    parameter int FRAME_WIDTH  = DEFAULT_FRAME_WIDTH,
    parameter int FRAME_HEIGHT = DEFAULT_FRAME_HEIGHT
) (
    input  wire logic      CLK,
    input  wire logic      RESET,
    gpu_ctrl_if.clear      ctrl,
    input  wire logic      clear_go,
    input  wire clear_target_e clear_target,
    output logic           clear_finish,
    output logic           master_chipselect,
    output logic           master_write,
    output bus_word_t      master_address,
    output bus_word_t      master_writedata,
    input  wire logic      master_waitrequest,
    input  wire logic      master_writeresponsevalid
);

    localparam int NUM_WORDS = FRAME_WIDTH * FRAME_HEIGHT;
    localparam int CNT_W     = $clog2(NUM_WORDS + 1);

    logic [CNT_W-1:0] count;    // word index inside the buffer
    logic             active;
    logic             go_q;
    logic             go_rise;
    logic             accept;
    logic             last_word;
    bus_word_t        base;

    assign go_rise   = clear_go && !go_q;
    assign accept    = active && master_writeresponsevalid && !master_waitrequest;
    assign last_word = (count == CNT_W'(NUM_WORDS - 1));

    assign clear_finish = accept && last_word;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            go_q   <= 1'b0;
            active <= 1'b0;
            count  <= '0;
        end else begin
            go_q <= clear_go;
            if (!clear_go) begin
                active <= 1'b0;  // run withdrawn
            end else if (go_rise) begin
                active <= 1'b1;
                count  <= '0;
            end else if (clear_finish) begin
                active <= 1'b0;
            end else if (accept) begin
                count <= count + 1'b1;
            end
        end
    end

    assign base = (clear_target == target_depth) ? ctrl.zbuf_ptr : ctrl.frame_ptr;

    // write held until the slave responds without waitrequest
    assign master_chipselect = active;
    assign master_write      = active;
    assign master_address    = base + bus_word_t'(count) * PIXEL_BYTES;
    assign master_writedata  = (clear_target == target_depth) ? DEPTH_FAR : SKY_COLOR;

    a_hold_pending_word : assert property (
        @(posedge CLK) disable iff (RESET)
        (master_write && !accept && clear_go) |=>
            master_write && $stable(master_address) && $stable(master_writedata)
    );

endmodule

`default_nettype wire

// ==== hw/gpu_core.sv ====
// top level: register file, sequencer and clear engine on slave and master ports
`timescale 1ns/1ns
`default_nettype none

module gpu_core
    import gpu_reg_pkg::*;
    import gpu_frame_pkg::*;
#(
    parameter int FRAME_WIDTH  = DEFAULT_FRAME_WIDTH,
    parameter int FRAME_HEIGHT = DEFAULT_FRAME_HEIGHT
) (
    input  wire logic      CLK,
    input  wire logic      RESET,
    // register slave
    input  wire logic      slave_chipselect,
    input  wire logic      slave_read,
    input  wire logic      slave_write,
    input  wire bus_word_t slave_address,
    input  wire bus_word_t slave_writedata,
    output bus_word_t      slave_readdata,
    // memory master, write only
    output logic           master_chipselect,
    output logic           master_write,
    output bus_word_t      master_address,
    output bus_word_t      master_writedata,
    input  wire logic      master_waitrequest,
    input  wire logic      master_writeresponsevalid
);

    logic          clear_go;
    clear_target_e clear_target;
    logic          clear_finish;

    gpu_ctrl_if ctrl_if ();

    gpu_regs i_regs (
        .CLK              (CLK),
        .RESET            (RESET),
        .slave_chipselect (slave_chipselect),
        .slave_read       (slave_read),
        .slave_write      (slave_write),
        .slave_address    (slave_address),
        .slave_writedata  (slave_writedata),
        .slave_readdata   (slave_readdata),
        .ctrl             (ctrl_if.regs)
    );

    gpu_sequencer i_sequencer (
        .CLK          (CLK),
        .RESET        (RESET),
        .ctrl         (ctrl_if.seq),
        .clear_go     (clear_go),
        .clear_target (clear_target),
        .clear_finish (clear_finish)
    );

    buffer_clear #(
        .FRAME_WIDTH  (FRAME_WIDTH),
        .FRAME_HEIGHT (FRAME_HEIGHT)
    ) i_clear (
        .CLK                       (CLK),
        .RESET                     (RESET),
        .ctrl                      (ctrl_if.clear),
        .clear_go                  (clear_go),
        .clear_target              (clear_target),
        .clear_finish              (clear_finish),
        .master_chipselect         (master_chipselect),
        .master_write              (master_write),
        .master_address            (master_address),
        .master_writedata          (master_writedata),
        .master_waitrequest        (master_waitrequest),
        .master_writeresponsevalid (master_writeresponsevalid)
    );

endmodule

`default_nettype wire

// ==== verif/gpu_mem_model.sv ====
// behavioral write memory with random waitrequest and response delay
`timescale 1ns/1ns
`default_nettype none

module gpu_mem_model
    import gpu_reg_pkg::*;
(
    input  wire logic      CLK,
    input  wire logic      RESET,
    input  wire logic      master_chipselect,
    input  wire logic      master_write,
    input  wire bus_word_t master_address,
    input  wire bus_word_t master_writedata,
    output logic           master_waitrequest,
    output logic           master_writeresponsevalid
);

    bus_word_t  mem [bus_word_t];
    bus_word_t  hits [bus_word_t];  // completed writes per address
    bus_word_t  total_writes;
    logic [1:0] delay;              // cycles left before the response

    function automatic bus_word_t peek(input bus_word_t addr);
        return mem.exists(addr) ? mem[addr] : '0;
    endfunction

    function automatic bus_word_t hits_at(input bus_word_t addr);
        return hits.exists(addr) ? hits[addr] : '0;
    endfunction

    // bus idle from time zero, before the first reset edge
    initial begin
        master_waitrequest        = 1'b0;
        master_writeresponsevalid = 1'b0;
    end

    always @(posedge CLK) begin
        if (RESET) begin
            master_waitrequest        <= 1'b0;
            master_writeresponsevalid <= 1'b0;
            delay                     <= 2'd0;
            total_writes              <= '0;
        end else if (master_chipselect && master_write) begin
            if (master_writeresponsevalid && !master_waitrequest) begin
                mem[master_address]  = master_writedata;  // word completes on this edge
                hits[master_address] = hits_at(master_address) + 32'd1;
                total_writes              <= total_writes + 32'd1;
                master_writeresponsevalid <= 1'b0;
                delay                     <= 2'($urandom_range(3, 0));
            end else if (delay != 2'd0) begin
                delay <= delay - 2'd1;
            end else begin
                master_writeresponsevalid <= 1'b1;
                master_waitrequest        <= ($urandom_range(3, 0) == 0);  // one in four stalls
            end
        end else begin
            master_writeresponsevalid <= 1'b0;
            master_waitrequest        <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== verif/gpu_core_tb.sv ====
// testbench for gpu_core: clock, reset, register tasks, reference model, checks, timeout
`timescale 1ns/1ns
`default_nettype none

module gpu_core_tb
    import gpu_reg_pkg::*;
;

    localparam int        SEED         = 31468;
    localparam int        FRAME_W      = 16;
    localparam int        FRAME_H      = 8;
    localparam int        NUM_WORDS    = FRAME_W * FRAME_H;
    localparam bus_word_t FRAME_BASE_A = 32'h0000_1000;
    localparam bus_word_t DEPTH_BASE   = 32'h0000_2000;
    localparam bus_word_t FRAME_BASE_B = 32'h0000_3000;
    localparam bus_word_t SKY_WORD     = 32'h0087_CEEB;
    localparam bus_word_t FAR_WORD     = 32'h7FFF_FFFF;
    localparam int        TOTAL_WORDS  = 3 * NUM_WORDS;  // three clears in the run
    localparam int        WORD_CYCLES  = 12;             // worst case per word with stalls
    localparam int        CYCLE_LIMIT  = 4 * TOTAL_WORDS * WORD_CYCLES + 2000;

    logic      CLK;
    logic      RESET;
    logic      slave_chipselect;
    logic      slave_read;
    logic      slave_write;
    bus_word_t slave_address;
    bus_word_t slave_writedata;
    bus_word_t slave_readdata;
    logic      master_chipselect;
    logic      master_write;
    bus_word_t master_address;
    bus_word_t master_writedata;
    logic      master_waitrequest;
    logic      master_writeresponsevalid;

    int        errors = 0;
    int        checks = 0;
    int        cycles = 0;
    logic      expect_writes;  // a clear run is in flight
    bus_word_t hist_base[$];   // base of every clear issued so far
    bus_word_t hist_data[$];

    gpu_core #(.FRAME_WIDTH(FRAME_W), .FRAME_HEIGHT(FRAME_H)) i_dut (.*);

    gpu_mem_model i_mem (.*);

    always #20 CLK = ~CLK;

    // expected word at addr, the newest clear covering it wins
    function automatic bus_word_t expected_word(input bus_word_t addr, output logic covered);
        bus_word_t w;
        w = '0;
        covered = 1'b0;
        foreach (hist_base[i]) begin
            if (addr >= hist_base[i] && addr < hist_base[i] + NUM_WORDS * 4
                    && addr[1:0] == 2'b00) begin
                w = hist_data[i];
                covered = 1'b1;
            end
        end
        return w;
    endfunction

    task automatic check_word(input string name, input bus_word_t exp, input bus_word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0t %s expected %08h actual %08h", $time, name, exp, act);
        end
    endtask

    task automatic check_mode(input string name, input gpu_mode_e exp, input gpu_mode_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0t %s expected %s(%0d) actual %s(%0d)", $time, name,
                     exp.name(), exp, act.name(), act);
        end
    endtask

    task automatic reg_write(input bus_word_t addr, input bus_word_t data);
        @(posedge CLK);
        slave_chipselect <= 1'b1;
        slave_write      <= 1'b1;
        slave_address    <= addr;
        slave_writedata  <= data;
        @(posedge CLK);
        slave_chipselect <= 1'b0;
        slave_write      <= 1'b0;
    endtask

    task automatic reg_read(input bus_word_t addr, output bus_word_t data);
        @(posedge CLK);
        slave_chipselect <= 1'b1;
        slave_read       <= 1'b1;
        slave_address    <= addr;
        @(negedge CLK);
        data = slave_readdata;  // combinational read, stable mid cycle
        @(posedge CLK);
        slave_chipselect <= 1'b0;
        slave_read       <= 1'b0;
    endtask

    task automatic wait_done();
        bus_word_t rd;
        rd = '0;
        while (rd[0] !== 1'b1) begin
            reg_read(reg_done, rd);
        end
    endtask

    // start one command and release it once done is seen
    task automatic run_command(input gpu_mode_e m, input bus_word_t base);
        logic is_clear;
        is_clear = (m == mode_clear_frame) || (m == mode_clear_depth);
        if (is_clear) begin
            hist_base.push_back(base);
            hist_data.push_back(m == mode_clear_depth ? FAR_WORD : SKY_WORD);
        end
        expect_writes <= is_clear;
        reg_write(reg_mode, bus_word_t'(m));
        reg_write(reg_start, 32'd1);
        wait_done();
        expect_writes <= 1'b0;
        reg_write(reg_start, 32'd0);
        reg_write(reg_done, 32'd0);
    endtask

    task automatic check_regions();
        bus_word_t addr;
        bus_word_t exp;
        logic      covered;
        foreach (hist_base[r]) begin
            for (int i = 0; i < NUM_WORDS; i++) begin
                addr = hist_base[r] + bus_word_t'(i * 4);
                exp  = expected_word(addr, covered);
                check_word("memory word", exp, i_mem.peek(addr));
                check_word("write count", 32'd1, i_mem.hits_at(addr));
            end
            check_word("writes below region", 32'd0, i_mem.hits_at(hist_base[r] - 32'd4));
            check_word("writes above region", 32'd0,
                       i_mem.hits_at(hist_base[r] + bus_word_t'(NUM_WORDS * 4)));
        end
        check_word("total writes", bus_word_t'(hist_base.size() * NUM_WORDS), i_mem.total_writes);
    endtask

    // every completed master write is checked against the reference
    always @(posedge CLK) begin
        bus_word_t exp;
        logic      covered;
        if (!RESET && !expect_writes && (master_write || master_chipselect)) begin
            errors++;
            $display("master bus active outside a clear run at %0t", $time);
        end
        if (!RESET && master_chipselect && master_write && master_writeresponsevalid
                && !master_waitrequest) begin
            exp = expected_word(master_address, covered);
            if (!expect_writes || !covered) begin
                errors++;
                $display("unexpected master write to %08h at %0t", master_address, $time);
            end else begin
                check_word("master_writedata", exp, master_writedata);
            end
        end
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, run did not finish", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        bus_word_t rd;
        void'($urandom(SEED));
        CLK              = 1'b0;
        RESET            = 1'b1;
        slave_chipselect = 1'b0;
        slave_read       = 1'b0;
        slave_write      = 1'b0;
        slave_address    = '0;
        slave_writedata  = '0;
        expect_writes    = 1'b0;
        repeat (4) @(posedge CLK);
        RESET <= 1'b0;

        // reset values
        reg_read(reg_done, rd);
        check_word("done", 32'd0, rd);
        reg_read(reg_mode, rd);
        check_mode("mode", mode_none, gpu_mode_e'(rd));
        reg_read(reg_frame_ptr, rd);
        check_word("frame_ptr", 32'd0, rd);
        reg_read(reg_zbuf_ptr, rd);
        check_word("zbuf_ptr", 32'd0, rd);
        check_word("total writes", 32'd0, i_mem.total_writes);

        // register readback
        reg_write(reg_frame_ptr, FRAME_BASE_A);
        reg_write(reg_zbuf_ptr, DEPTH_BASE);
        reg_write(reg_mode, bus_word_t'(mode_clear_depth));
        reg_read(reg_frame_ptr, rd);
        check_word("frame_ptr", FRAME_BASE_A, rd);
        reg_read(reg_zbuf_ptr, rd);
        check_word("zbuf_ptr", DEPTH_BASE, rd);
        reg_read(reg_mode, rd);
        check_mode("mode", mode_clear_depth, gpu_mode_e'(rd));
        reg_read(32'd5, rd);
        check_word("unmapped read", 32'd0, rd);

        run_command(mode_clear_frame, FRAME_BASE_A);
        check_regions();
        run_command(mode_clear_depth, DEPTH_BASE);
        check_regions();  // frame region must be untouched

        // unsupported modes finish without memory traffic
        run_command(mode_cube, '0);
        run_command(mode_none, '0);
        check_word("total writes", bus_word_t'(2 * NUM_WORDS), i_mem.total_writes);

        reg_write(reg_frame_ptr, FRAME_BASE_B);
        run_command(mode_clear_frame, FRAME_BASE_B);
        check_regions();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
hw/gpu_reg_pkg.sv
hw/gpu_frame_pkg.sv
hw/gpu_ctrl_if.sv
hw/gpu_regs.sv
hw/gpu_sequencer.sv
hw/buffer_clear.sv
hw/gpu_core.sv
verif/gpu_mem_model.sv
verif/gpu_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the gpu_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module gpu_core_tb -Mdir obj_dir -o gpu_core_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/gpu_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0
